// File: common/vproc_defs.svh
/*
 vproc core parameters.
 Instruction and data widths, register file size, lane count
 and result queue depth shared by every vproc block.
*/
`ifndef VPROC_DEFS_SVH
`define VPROC_DEFS_SVH

// Host instruction word.
`define VPROC_INSTR_W 24

// Scalar register and vector lane width.
`define VPROC_DATA_W 16

`define VPROC_LANES 4 // Lanes per vector register.

// Full vector register width.
`define VPROC_VEC_W (`VPROC_DATA_W * `VPROC_LANES)

`define VPROC_REGS 16 // Registers per file.

// Result queue depth, also the host credits after reset.
`define VPROC_RES_DEPTH 4

`endif

// File: common/vproc_pkg.sv
/*
 vproc shared types.
 Opcode and func encodings, instruction, issue and result words,
 the dnt bubble and the 16-bit ALU used by both datapaths.
*/
`include "vproc_defs.svh"

package vproc_pkg;

	typedef enum logic [2:0] {
		OP_SARITH = 3'b000, // Scalar arithmetic.
		OP_VARITH = 3'b001, // Vector arithmetic.
		OP_SIMM   = 3'b010, // Scalar immediate.
		OP_SMEM   = 3'b011, // Scalar memory, not executed.
		OP_VMGMT  = 3'b100, // Vector management.
		OP_VMEM   = 3'b101, // Vector memory, not executed.
		OP_BRANCH = 3'b110, // Branch, not executed.
		OP_DNT    = 3'b111  // Do nothing.
	} opcode_e;

	// Immediate forms reuse F_ADD as add-immediate and F_SUB as load-immediate.
	typedef enum logic [2:0] {
		F_ADD = 3'b000,
		F_SUB = 3'b001,
		F_AND = 3'b010,
		F_OR  = 3'b011,
		F_XOR = 3'b100,
		F_SLL = 3'b101,
		F_SRL = 3'b110,
		F_SLT = 3'b111
	} func_e;

	typedef struct packed {
		opcode_e    opcode;
		logic       s1;    // Carried, unused.
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [3:0] shamt;
		func_e      func;
		logic       s0;    // Carried, unused.
	} instr_t;

	// All-ones bubble.
	localparam instr_t DNT_INSTR = instr_t'({`VPROC_INSTR_W{1'b1}});

	typedef struct packed {
		logic   valid;
		instr_t instr;
	} issue_t;

	typedef enum logic [1:0] {
		RES_NONE   = 2'd0, // Retired without a value.
		RES_SCALAR = 2'd1,
		RES_VECTOR = 2'd2
	} res_kind_e;

	typedef struct packed {
		logic                    valid;
		res_kind_e               kind;
		logic [3:0]              rd;
		logic [`VPROC_VEC_W-1:0] value; // Scalar sits in the low bits.
	} result_t;

	// One 16-bit ALU slice, scalar path and each vector lane.
	function automatic logic [`VPROC_DATA_W-1:0] alu_op(
		input func_e                    func,
		input logic [`VPROC_DATA_W-1:0] a,
		input logic [`VPROC_DATA_W-1:0] b,
		input logic [3:0]               shamt
	);
		case (func)
			F_ADD:   alu_op = a + b;
			F_SUB:   alu_op = a - b;
			F_AND:   alu_op = a & b;
			F_OR:    alu_op = a | b;
			F_XOR:   alu_op = a ^ b;
			F_SLL:   alu_op = a << shamt; // Shift by shamt, not rt.
			F_SRL:   alu_op = a >> shamt;
			default: alu_op = {{(`VPROC_DATA_W-1){1'b0}}, (a < b)}; // Unsigned compare.
		endcase
	endfunction

endpackage

// File: design/datapath_selector.sv
/*
 Datapath selector, decode stage.
 Routes each host instruction to the scalar or vector datapath by
 opcode and feeds the dnt bubble to the other. Opcode 111 goes to
 neither and is flagged for direct retirement.
*/
`timescale 1ns/100ps

module datapath_selector (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                in_valid,
	input  vproc_pkg::instr_t   in_instr,
	output vproc_pkg::issue_t   scalar_issue,
	output vproc_pkg::issue_t   vector_issue,
	output logic                dnt_retire
);

	logic to_scalar; // Opcode belongs to the scalar group.
	logic to_vector; // Opcode belongs to the vector group.

	always_comb begin
		to_scalar = 1'b0;
		to_vector = 1'b0;
		case (in_instr.opcode)
			vproc_pkg::OP_SARITH,
			vproc_pkg::OP_SIMM,
			vproc_pkg::OP_SMEM,
			vproc_pkg::OP_BRANCH: to_scalar = 1'b1;
			vproc_pkg::OP_VARITH,
			vproc_pkg::OP_VMGMT,
			vproc_pkg::OP_VMEM:   to_vector = 1'b1;
			default: ; // Opcode 111, neither path.
		endcase
	end

	// Issue words land one cycle after acceptance.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scalar_issue <= '{valid: 1'b0, instr: vproc_pkg::DNT_INSTR};
			vector_issue <= '{valid: 1'b0, instr: vproc_pkg::DNT_INSTR};
			dnt_retire   <= 1'b0;
		end else begin
			// Unchosen path sees the bubble.
			scalar_issue <= '{valid: 1'b0, instr: vproc_pkg::DNT_INSTR};
			vector_issue <= '{valid: 1'b0, instr: vproc_pkg::DNT_INSTR};
			if (in_valid && to_scalar) begin
				scalar_issue <= '{valid: 1'b1, instr: in_instr};
			end
			if (in_valid && to_vector) begin
				vector_issue <= '{valid: 1'b1, instr: in_instr};
			end
			dnt_retire <= in_valid && !to_scalar && !to_vector; // Credit only.
		end
	end

endmodule

// File: scalar/scalar_execute.sv
/*
 Scalar execute stage.
 Sixteen 16-bit registers and the scalar ALU, including the
 add-immediate and load-immediate forms. Emits one result per issue,
 RES_NONE for forms that are routed here but not executed.
*/
`timescale 1ns/100ps
`include "vproc_defs.svh"

module scalar_execute (
	input  logic                clk,
	input  logic                arst_n,
	input  vproc_pkg::issue_t   issue,
	output vproc_pkg::result_t  res
);

	localparam int DW = `VPROC_DATA_W;

	logic [DW-1:0]     regs [`VPROC_REGS]; // Scalar register file.
	vproc_pkg::instr_t ins;
	logic [DW-1:0]     op_a;   // rs operand.
	logic [DW-1:0]     op_b;   // rt operand.
	logic [DW-1:0]     imm;    // {rt,shamt} zero-extended.
	logic [DW-1:0]     wr_val;
	logic              wr_en;  // Form produces a value.

	assign ins = issue.instr;

	always_comb begin
		op_a   = regs[ins.rs];
		op_b   = regs[ins.rt];
		imm    = DW'({ins.rt, ins.shamt});
		wr_en  = 1'b0;
		wr_val = '0;
		case (ins.opcode)
			vproc_pkg::OP_SARITH: begin
				wr_en  = 1'b1; // All eight funcs valid.
				wr_val = vproc_pkg::alu_op(ins.func, op_a, op_b, ins.shamt);
			end
			vproc_pkg::OP_SIMM: begin
				case (ins.func)
					vproc_pkg::F_ADD: begin
						wr_en  = 1'b1;
						wr_val = op_a + imm; // Add-immediate.
					end
					vproc_pkg::F_SUB: begin
						wr_en  = 1'b1;
						wr_val = imm; // Load-immediate.
					end
					default: ; // Unused immediate func.
				endcase
			end
			default: ; // Memory and branch retire empty.
		endcase
	end

	// Write back at the same edge the result registers.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `VPROC_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (issue.valid && wr_en) begin
			regs[ins.rd] <= wr_val;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res <= '0;
		end else begin
			res.valid <= issue.valid;
			res.kind  <= (issue.valid && wr_en) ? vproc_pkg::RES_SCALAR : vproc_pkg::RES_NONE;
			res.rd    <= ins.rd;
			res.value <= `VPROC_VEC_W'(wr_val); // Upper bits zero.
		end
	end

endmodule

// File: vector/vector_execute.sv
/*
 Vector execute stage.
 Sixteen 64-bit vector registers, each four 16-bit lanes. Runs the
 scalar func set independently per lane and splats an immediate to
 all lanes. Vector memory and unused management funcs retire empty.
*/
`timescale 1ns/100ps
`include "vproc_defs.svh"

module vector_execute (
	input  logic                clk,
	input  logic                arst_n,
	input  vproc_pkg::issue_t   issue,
	output vproc_pkg::result_t  res
);

	localparam int DW = `VPROC_DATA_W;
	localparam int VW = `VPROC_VEC_W;

	logic [VW-1:0]     vregs [`VPROC_REGS]; // Vector register file.
	vproc_pkg::instr_t ins;
	logic [VW-1:0]     vec_a;   // rs vector.
	logic [VW-1:0]     vec_b;   // rt vector.
	logic [VW-1:0]     lane_res; // Lane-wise ALU output.
	logic [DW-1:0]     imm;
	logic [VW-1:0]     wr_val;
	logic              wr_en;

	assign ins   = issue.instr;
	assign vec_a = vregs[ins.rs];
	assign vec_b = vregs[ins.rt];
	assign imm   = DW'({ins.rt, ins.shamt});

	// Each lane is its own 16-bit slice, no carry crosses.
	always_comb begin
		for (int l = 0; l < `VPROC_LANES; l++) begin
			lane_res[l*DW +: DW] = vproc_pkg::alu_op(ins.func, vec_a[l*DW +: DW],
				vec_b[l*DW +: DW], ins.shamt);
		end
	end

	always_comb begin
		wr_en  = 1'b0;
		wr_val = lane_res;
		case (ins.opcode)
			vproc_pkg::OP_VARITH: begin
				wr_en = 1'b1;
			end
			vproc_pkg::OP_VMGMT: begin
				if (ins.func == vproc_pkg::F_ADD) begin
					wr_en  = 1'b1;
					wr_val = {`VPROC_LANES{imm}}; // Splat.
				end
			end
			default: ; // Vector memory retires empty.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `VPROC_REGS; i++) begin
				vregs[i] <= '0;
			end
		end else if (issue.valid && wr_en) begin
			vregs[ins.rd] <= wr_val;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res <= '0;
		end else begin
			res.valid <= issue.valid;
			res.kind  <= (issue.valid && wr_en) ? vproc_pkg::RES_VECTOR : vproc_pkg::RES_NONE;
			res.rd    <= ins.rd;
			res.value <= wr_val;
		end
	end

endmodule

// File: design/result_merge.sv
/*
 Result merge stage.
 Queues valued results from both datapaths in issue order and sends
 them out under output credits. Returns one input credit per retired
 instruction, valued or not.
*/
`timescale 1ns/100ps
`include "vproc_defs.svh"

module result_merge (
	input  logic                clk,
	input  logic                arst_n,
	input  vproc_pkg::result_t  scalar_res,
	input  vproc_pkg::result_t  vector_res,
	input  logic                dnt_retire,
	input  logic                out_credit,
	output logic                res_valid,
	output vproc_pkg::result_t  res,
	output logic                in_credit
);

	localparam int DEPTH = `VPROC_RES_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int RET_W = CNT_W + 1;

	vproc_pkg::result_t fifo_mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   fifo_count;
	logic [CNT_W-1:0]   out_credits; // Output credits held.
	logic [CNT_W-1:0]   owed;        // Input credits not yet pulsed.
	logic [RET_W-1:0]   ret_sum;
	logic               dnt_d;       // dnt_retire aligned to execute.
	vproc_pkg::result_t in_res;
	vproc_pkg::result_t head;
	logic               in_val;      // Valued result arriving.
	logic               in_none;     // Empty retirement arriving.
	logic               fifo_empty;
	logic               pop;
	logic               push;

	assign in_res     = scalar_res.valid ? scalar_res : vector_res; // Never both.
	assign in_val     = in_res.valid && (in_res.kind != vproc_pkg::RES_NONE);
	assign in_none    = (in_res.valid && (in_res.kind == vproc_pkg::RES_NONE)) || dnt_d;
	assign fifo_empty = (fifo_count == '0);
	assign head       = fifo_empty ? in_res : fifo_mem[rd_ptr]; // Bypass when empty.
	assign pop        = (out_credits != '0) && (!fifo_empty || in_val);
	assign push       = in_val && !(fifo_empty && pop);
	assign ret_sum    = {1'b0, owed} + RET_W'(pop) + RET_W'(in_none);

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= in_res;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			fifo_count  <= '0;
			out_credits <= '0;
			owed        <= '0;
			dnt_d       <= 1'b0;
			in_credit   <= 1'b0;
			res_valid   <= 1'b0;
			res         <= '0;
		end else begin
			dnt_d <= dnt_retire;
			if (push) wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two.
			if (pop && !fifo_empty) rd_ptr <= rd_ptr + 1'b1;
			fifo_count <= fifo_count + CNT_W'(push) - CNT_W'(pop && !fifo_empty);
			// Grants beyond the queue depth saturate.
			if (out_credit && !pop && (out_credits != CNT_W'(DEPTH))) begin
				out_credits <= out_credits + 1'b1;
			end else if (!out_credit && pop) begin
				out_credits <= out_credits - 1'b1;
			end
			// One pulse per cycle, extras wait in owed.
			in_credit <= (ret_sum != '0);
			if (ret_sum != '0) owed <= CNT_W'(ret_sum - 1'b1);
			res_valid <= pop;
			res       <= pop ? head : '0;
		end
	end

endmodule

// File: design/vproc_top.sv
/*
 vproc top level.
 Decode feeds the scalar and vector execute stages, whose results
 are merged in issue order behind credit-based input and output.
*/
`timescale 1ns/100ps

module vproc_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                in_valid,
	input  vproc_pkg::instr_t   in_instr,
	output logic                in_credit,
	input  logic                out_credit,
	output logic                res_valid,
	output vproc_pkg::result_t  res
);

	vproc_pkg::issue_t  scalar_issue;
	vproc_pkg::issue_t  vector_issue;
	vproc_pkg::result_t scalar_res;
	vproc_pkg::result_t vector_res;
	logic               dnt_retire; // Opcode 111, credit only.

	datapath_selector u_sel (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.in_instr     (in_instr),
		.scalar_issue (scalar_issue),
		.vector_issue (vector_issue),
		.dnt_retire   (dnt_retire)
	);

	scalar_execute u_sexe (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (scalar_issue),
		.res    (scalar_res)
	);

	vector_execute u_vexe (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (vector_issue),
		.res    (vector_res)
	);

	result_merge u_merge (
		.clk        (clk),
		.arst_n     (arst_n),
		.scalar_res (scalar_res),
		.vector_res (vector_res),
		.dnt_retire (dnt_retire),
		.out_credit (out_credit),
		.res_valid  (res_valid),
		.res        (res),
		.in_credit  (in_credit)
	);

endmodule

// File: tests/vproc_props.sv
/*
 vproc result merge properties.
 Concurrent checks on output credits, queue bounds, datapath
 exclusivity and input credits under reset. Bound to result_merge.
*/
`timescale 1ns/100ps
`include "vproc_defs.svh"

module vproc_props #(
	parameter int CNT_W = $clog2(`VPROC_RES_DEPTH + 1)
) (
	input logic               clk,
	input logic               arst_n,
	input logic               out_credit,
	input logic               res_valid,
	input logic               in_credit,
	input logic [CNT_W-1:0]   fifo_count,
	input vproc_pkg::result_t scalar_res,
	input vproc_pkg::result_t vector_res
);

	int grants_held; // Grants seen on the port less results sent.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			grants_held <= 0;
		end else begin
			grants_held <= grants_held + int'(out_credit) - int'(res_valid);
		end
	end

	// A result needs a grant that the sink has not yet seen used.
	res_on_credit: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> (grants_held != 0))
		else $error("result sent with no output credit held");

	fifo_bound: assert property (@(posedge clk) disable iff (!arst_n)
		fifo_count <= CNT_W'(`VPROC_RES_DEPTH)) // Queue depth limit.
		else $error("result queue above its depth");

	// Each instruction reaches one datapath only.
	one_datapath: assert property (@(posedge clk) disable iff (!arst_n)
		!(scalar_res.valid && vector_res.valid))
		else $error("scalar and vector results valid together");

	credit_in_reset: assert property (@(posedge clk) !arst_n |-> !in_credit)
		else $error("input credit returned during reset");

endmodule

bind result_merge vproc_props u_props (
	.clk         (clk),
	.arst_n      (arst_n),
	.out_credit  (out_credit),
	.res_valid   (res_valid),
	.in_credit   (in_credit),
	.fifo_count  (fifo_count),
	.scalar_res  (scalar_res),
	.vector_res  (vector_res)
);

// File: tests/vproc_tb.sv
/*
 vproc testbench.
 Streams instructions under input credits, grants output credits
 and checks every result against shadow register files.
*/
`timescale 1ns/100ps
`include "vproc_defs.svh"

module vproc_tb;

	localparam int DW      = `VPROC_DATA_W;
	localparam int VW      = `VPROC_VEC_W;
	localparam int DEPTH   = `VPROC_RES_DEPTH;
	localparam int N_TOTAL = 32 + 40 + 40 + 8 + 12; // Instructions over all tests.
	localparam int TIMEOUT = 8 * N_TOTAL + 200;
	localparam logic [1:0] SINK_EVERY  = 2'd0;
	localparam logic [1:0] SINK_RANDOM = 2'd1;
	localparam logic [1:0] SINK_HOLD   = 2'd2;

	logic               clk;
	logic               arst_n;
	logic               in_valid;
	vproc_pkg::instr_t  in_instr;
	logic               in_credit;
	logic               out_credit;
	logic               res_valid;
	vproc_pkg::result_t res;

	logic [DW-1:0]      sregs [`VPROC_REGS]; // Shadow scalar file.
	logic [VW-1:0]      vregs [`VPROC_REGS]; // Shadow vector file.
	vproc_pkg::result_t exp_q [$];           // Expected results, issue order.
	vproc_pkg::result_t exp_res;
	logic [1:0]         sink_mode;
	logic [1:0]         mode_q;              // Mode seen by the sink.
	logic [31:0]        roll;                // Sink grant draw.
	integer             seed;
	string              test_name;
	int host_credits = DEPTH;
	int granted      = 0; // Output credits not yet used.
	int cycle        = 0;
	int test_errs    = 0;
	int err_total    = 0;
	int tests_run    = 0;
	int tests_bad    = 0;

	vproc_top dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_credit  (in_credit),
		.out_credit (out_credit),
		.res_valid  (res_valid),
		.res        (res)
	);

	always #20 clk = ~clk;

	// One 16-bit slice by the func table.
	function automatic logic [DW-1:0] lane_calc(input logic [2:0] func,
		input logic [DW-1:0] a, input logic [DW-1:0] b, input logic [3:0] sh);
		case (func)
			3'd0: lane_calc = a + b;
			3'd1: lane_calc = a - b;
			3'd2: lane_calc = a & b;
			3'd3: lane_calc = a | b;
			3'd4: lane_calc = a ^ b;
			3'd5: lane_calc = a << sh;
			3'd6: lane_calc = a >> sh;
			default: lane_calc = (a < b) ? DW'(1) : DW'(0); // Unsigned.
		endcase
	endfunction

	function automatic vproc_pkg::result_t ref_exec(input vproc_pkg::instr_t ins);
		vproc_pkg::result_t r;
		logic [DW-1:0]      imm;
		logic [VW-1:0]      v;
		r   = '0;
		imm = DW'({ins.rt, ins.shamt});
		case (ins.opcode)
			vproc_pkg::OP_SARITH: begin
				sregs[ins.rd] = lane_calc(ins.func, sregs[ins.rs], sregs[ins.rt], ins.shamt);
				r.kind = vproc_pkg::RES_SCALAR;
			end
			vproc_pkg::OP_SIMM: begin
				if (ins.func == vproc_pkg::F_ADD || ins.func == vproc_pkg::F_SUB) begin
					sregs[ins.rd] = (ins.func == vproc_pkg::F_ADD) ? sregs[ins.rs] + imm : imm;
					r.kind = vproc_pkg::RES_SCALAR;
				end
			end
			vproc_pkg::OP_VARITH: begin
				for (int l = 0; l < `VPROC_LANES; l++) begin
					v[l*DW +: DW] = lane_calc(ins.func, vregs[ins.rs][l*DW +: DW],
						vregs[ins.rt][l*DW +: DW], ins.shamt);
				end
				vregs[ins.rd] = v;
				r.kind = vproc_pkg::RES_VECTOR;
			end
			vproc_pkg::OP_VMGMT: begin
				if (ins.func == vproc_pkg::F_ADD) begin
					vregs[ins.rd] = {`VPROC_LANES{imm}}; // Splat.
					r.kind = vproc_pkg::RES_VECTOR;
				end
			end
			default: ; // Retires with no value.
		endcase
		r.valid = (r.kind != vproc_pkg::RES_NONE);
		r.rd    = ins.rd;
		r.value = (r.kind == vproc_pkg::RES_SCALAR) ? VW'(sregs[ins.rd]) : vregs[ins.rd];
		return r;
	endfunction

	function automatic vproc_pkg::instr_t make_instr(input logic [2:0] op, input logic [3:0] rd,
		input logic [3:0] rt, input logic [3:0] shamt, input logic [2:0] func);
		vproc_pkg::instr_t ins;
		ins        = '0;
		ins.opcode = vproc_pkg::opcode_e'(op);
		ins.rd     = rd;
		ins.rt     = rt;
		ins.shamt  = shamt;
		ins.func   = vproc_pkg::func_e'(func);
		return ins;
	endfunction

	// Random fields; vec picks lane-wise, else R-type or add-immediate.
	function automatic vproc_pkg::instr_t rand_instr(input logic vec);
		logic [31:0]       r;
		vproc_pkg::instr_t ins;
		r   = $random(seed);
		ins = vproc_pkg::instr_t'(r[23:0]);
		if (vec) begin
			ins.opcode = vproc_pkg::OP_VARITH;
		end else if (r[31:30] == 2'b00) begin
			ins.opcode = vproc_pkg::OP_SIMM;
			ins.func   = vproc_pkg::F_ADD;
		end else begin
			ins.opcode = vproc_pkg::OP_SARITH;
		end
		return ins;
	endfunction

	task automatic check_value(input string name, input logic [$bits(res)-1:0] exp,
		input logic [$bits(res)-1:0] act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			test_errs++;
			err_total++;
		end
	endtask

	// Waits on a falling edge for a free credit.
	task automatic issue_instr(input vproc_pkg::instr_t ins);
		@(negedge clk);
		in_valid = 1'b0;
		while (host_credits == 0) begin
			@(negedge clk);
		end
		in_valid = 1'b1;
		in_instr = ins;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		int waited;
		waited = 0;
		idle_cycles(1);
		while ((exp_q.size() != 0 || host_credits != DEPTH) && waited < 150) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Test %s: %0d expected results never came out", test_name, exp_q.size());
			test_errs++;
			err_total++;
		end
		if (host_credits != DEPTH) begin
			$display("Test %s: credits not all returned, host holds %0d of %0d",
				test_name, host_credits, DEPTH);
			test_errs++;
			err_total++;
		end
		tests_run++;
		if (test_errs != 0) tests_bad++;
		$display("Test %0d %s: %s, %0d errors", tests_run, test_name,
			(test_errs == 0) ? "ok" : "failed", test_errs);
	endtask

	// Credits, reference model and compare, all on the rising edge.
	always @(posedge clk) begin
		if (arst_n) begin
			if (res_valid) begin
				if (exp_q.size() == 0) begin
					$display("Test %s: unexpected result for rd %0d", test_name, res.rd);
					test_errs++;
					err_total++;
				end else begin
					exp_res = exp_q.pop_front();
					check_value(test_name, exp_res, res);
				end
				granted--;
			end
			if (out_credit) granted++;
			if (in_credit) host_credits++;
			if (in_valid) begin
				host_credits--;
				exp_res = ref_exec(in_instr);
				if (exp_res.valid) exp_q.push_back(exp_res);
			end
			mode_q = sink_mode;
			roll   = $random(seed);
		end
	end

	// Sink grants only what pending results need.
	always @(negedge clk) begin
		if (!arst_n || mode_q == SINK_HOLD) begin
			out_credit = 1'b0;
		end else begin
			out_credit = (exp_q.size() > granted) && (mode_q == SINK_EVERY || roll[1:0] == 2'b00);
		end
	end

	always @(posedge clk) begin
		cycle++;
		if (cycle >= TIMEOUT) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		seed      = 15;
		clk       = 1'b0;
		arst_n    = 1'b1;
		in_valid  = 1'b0;
		in_instr  = vproc_pkg::DNT_INSTR;
		out_credit = 1'b0;
		sink_mode = SINK_EVERY;
		mode_q    = SINK_EVERY;
		roll      = '0;
		for (int i = 0; i < `VPROC_REGS; i++) begin
			sregs[i] = '0;
			vregs[i] = '0;
		end
		#5 arst_n = 1'b0; // Clean falling edge.
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		start_test("imm_loads");
		for (int i = 0; i < 16; i++) issue_instr(make_instr(3'b010, 4'(i), 4'(i), 4'(15 - i), 3'b001));
		for (int i = 0; i < 16; i++) issue_instr(make_instr(3'b100, 4'(i), 4'(i ^ 5), 4'(i + 9), 3'b000));
		end_test();

		start_test("scalar_arith");
		for (int i = 0; i < 40; i++) issue_instr(rand_instr(1'b0));
		end_test();

		start_test("vector_arith");
		sink_mode = SINK_RANDOM;
		for (int i = 0; i < 40; i++) issue_instr(rand_instr(1'b1));
		end_test();

		start_test("unexecuted");
		sink_mode = SINK_EVERY;
		issue_instr(make_instr(3'b011, 4'd1, 4'd2, 4'd3, 3'b000)); // Scalar memory.
		issue_instr(make_instr(3'b101, 4'd2, 4'd3, 4'd4, 3'b000)); // Vector memory.
		issue_instr(make_instr(3'b110, 4'd3, 4'd4, 4'd5, 3'b010)); // Branch.
		issue_instr(make_instr(3'b111, 4'd4, 4'd0, 4'd0, 3'b000));
		issue_instr(vproc_pkg::DNT_INSTR);
		issue_instr(make_instr(3'b010, 4'd5, 4'd6, 4'd7, 3'b010)); // Unused immediate func.
		issue_instr(make_instr(3'b010, 4'd6, 4'd7, 4'd8, 3'b111));
		issue_instr(make_instr(3'b100, 4'd7, 4'd8, 4'd9, 3'b001)); // Unused management func.
		end_test();

		start_test("back_pressure");
		sink_mode = SINK_HOLD;
		for (int i = 0; i < DEPTH; i++) issue_instr(rand_instr(i[0]));
		idle_cycles(12);
		if (host_credits != 0 || exp_q.size() != DEPTH) begin
			$display("Test %s: results left while the sink held its credits", test_name);
			test_errs++;
			err_total++;
		end
		sink_mode = SINK_RANDOM;
		for (int i = 0; i < 8; i++) issue_instr(rand_instr(i[0]));
		end_test();

		$display("Summary: %0d tests run, %0d with errors, %0d errors total",
			tests_run, tests_bad, err_total);
		if (err_total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: vproc.f
+incdir+common
common/vproc_pkg.sv
design/datapath_selector.sv
scalar/scalar_execute.sv
vector/vector_execute.sv
design/result_merge.sv
design/vproc_top.sv
tests/vproc_props.sv
tests/vproc_tb.sv

// File: run.sh
#!/bin/sh
# Compile the vproc testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module vproc_tb -f vproc.f \
	&& ./obj_dir/Vvproc_tb > sim.log 2>&1 \
	|| echo "build or simulation error" >> sim.log
cat sim.log
grep -q "All checks passed" sim.log && exit 0 || exit 1
